//--- sim/tb_fifo_credit_top.sv
// Credit FIFO directed testbench
`include "cfifo_params.svh"

module tb_fifo_credit_top
  import cfifo_pkg::*;
();

  // Five tests of a few hundred cycles each plus ample margin
  localparam int MAX_CYCLES = 4000;
  localparam int DEPTH      = `CFIFO_DEPTH;

  logic    clk;
  logic    rst_n;
  logic    push_credit_stall;
  logic    push_credit;
  logic    push_valid;
  data_t   push_data;
  credit_t credit_withhold;
  credit_t credit_available;
  logic    full;
  count_t  slots;
  logic    pop_ready;
  logic    pop_valid;
  data_t   pop_data;
  count_t  items;

  // Sender and scoreboard state
  int      sender_credits;
  int      credit_pulses;
  int      error_count;
  int      check_count;
  int      cycle_count;
  integer  seed;
  data_t   model_q [$];

  fifo_credit_top fifo_credit_top_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .push_credit_stall(push_credit_stall),
    .push_credit      (push_credit),
    .push_valid       (push_valid),
    .push_data        (push_data),
    .credit_withhold  (credit_withhold),
    .credit_available (credit_available),
    .full             (full),
    .slots            (slots),
    .pop_ready        (pop_ready),
    .pop_valid        (pop_valid),
    .pop_data         (pop_data),
    .items            (items)
  );

  // ------------------------------------------------------------
  // Clock, watchdog and monitor
  // ------------------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the tests did not complete within %0d cycles", MAX_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  task automatic check_equal(input string sig, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("error: %s got %h expected %h", sig, got, exp);
    end
  endtask

  // Mid-cycle view of what commits at the next edge
  always @(negedge clk) begin
    data_t expected;
    if (rst_n) begin
      // Push first since a bypassed word leaves in the same cycle
      if (push_valid) begin
        sender_credits--;
        model_q.push_back(push_data);
      end
      if (push_credit) begin
        sender_credits++;
        credit_pulses++;
      end
      if (pop_valid && pop_ready) begin
        check_count++;
        assert (model_q.size() != 0) else begin
          error_count++;
          $display("FIFO popped a word while none was expected");
        end
        if (model_q.size() != 0) begin
          expected = model_q.pop_front();
          check_equal("pop_data", pop_data, expected);
        end
      end
      // Stall must hold back every pulse
      check_count++;
      assert (!(push_credit_stall && push_credit)) else begin
        error_count++;
        $display("Credit pulse issued while push_credit_stall was high");
      end
      // Credits plus stored words bounded by storage
      check_count++;
      assert (sender_credits + model_q.size() <= DEPTH) else begin
        error_count++;
        $display("Sender credits plus words in flight exceed the FIFO depth");
      end
    end
  end

  // ------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------

  // Inputs change shortly after the rising edge
  task automatic next_drive();
    @(posedge clk);
    #2;
  endtask

  // Waits for a credit, then pushes for one cycle
  task automatic push_word(input data_t d);
    while (sender_credits == 0) begin
      push_valid = 1'b0;
      next_drive();
    end
    push_valid = 1'b1;
    push_data  = d;
    next_drive();
    push_valid = 1'b0;
  endtask

  task automatic drain_until_credits(input int target);
    pop_ready  = 1'b1;
    push_valid = 1'b0;
    while (model_q.size() != 0 || sender_credits < target) begin
      next_drive();
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("test %s finished, %0d errors", name, error_count - errors_before);
  endtask

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------

  task automatic initial_credit_pulses();
    int errs;
    errs = error_count;
    while (sender_credits < DEPTH) begin
      next_drive();
    end
    // Nothing popped, so the pool stays empty
    repeat (10) next_drive();
    @(negedge clk);
    check_equal("sender_credits", sender_credits, DEPTH);
    check_equal("push_credit", push_credit, 0);
    check_equal("credit_available", credit_available, 0);
    next_drive();
    report_test("initial_credits", errs);
  endtask

  task automatic fill_then_drain();
    int errs;
    int pulses_before;
    errs = error_count;
    pop_ready = 1'b0;
    repeat (DEPTH) push_word($random(seed));
    next_drive();
    @(negedge clk);
    check_equal("full", full, 1);
    check_equal("slots", slots, 0);
    check_equal("items", items, DEPTH);
    next_drive();
    pulses_before = credit_pulses;
    drain_until_credits(DEPTH);
    @(negedge clk);
    check_equal("returned credits", credit_pulses - pulses_before, DEPTH);
    check_equal("full", full, 0);
    check_equal("slots", slots, DEPTH);
    next_drive();
    report_test("fill_drain", errs);
  endtask

  task automatic bypass_same_cycle();
    int    errs;
    data_t d;
    errs      = error_count;
    d         = $random(seed);
    pop_ready = 1'b1;
    push_valid = 1'b1;
    push_data  = d;
    // Word must reach the output in this same cycle
    @(negedge clk);
    check_equal("pop_valid", pop_valid, 1);
    check_equal("pop_data", pop_data, d);
    next_drive();
    push_valid = 1'b0;
    // Nothing stored and the credit is back in the pool
    @(negedge clk);
    check_equal("items", items, 0);
    check_equal("push_credit", push_credit, 1);
    next_drive();
    drain_until_credits(DEPTH);
    report_test("bypass", errs);
  endtask

  task automatic random_traffic();
    int errs;
    errs = error_count;
    repeat (200) begin
      pop_ready  = $random(seed) & 1;
      push_data  = $random(seed);
      push_valid = (sender_credits > 0) && (($random(seed) & 1) != 0);
      next_drive();
    end
    drain_until_credits(DEPTH);
    @(negedge clk);
    check_equal("sender_credits", sender_credits, DEPTH);
    check_equal("items", items, 0);
    next_drive();
    report_test("random_traffic", errs);
  endtask

  task automatic stall_and_withhold();
    int errs;
    int pulses_before;
    errs = error_count;
    // Stalled returns stay in the pool
    push_credit_stall = 1'b1;
    pop_ready         = 1'b1;
    pulses_before     = credit_pulses;
    repeat (4) push_word($random(seed));
    repeat (6) next_drive();
    check_count++;
    assert (credit_pulses == pulses_before) else begin
      error_count++;
      $display("Credit pulses appeared while push_credit_stall was high");
    end
    push_credit_stall = 1'b0;
    drain_until_credits(DEPTH);
    // Withhold part of the pool and then fill and drain
    credit_withhold = credit_t'(3);
    pop_ready       = 1'b0;
    repeat (DEPTH) push_word($random(seed));
    drain_until_credits(DEPTH - 3);
    repeat (10) next_drive();
    @(negedge clk);
    check_equal("sender_credits", sender_credits, DEPTH - 3);
    check_equal("credit_available", credit_available, 0);
    next_drive();
    credit_withhold = '0;
    drain_until_credits(DEPTH);
    report_test("stall_withhold", errs);
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------

  initial begin
    seed              = 32'h4e4f3f51;
    sender_credits    = 0;
    credit_pulses     = 0;
    error_count       = 0;
    check_count       = 0;
    cycle_count       = 0;
    rst_n             = 1'b0;
    push_credit_stall = 1'b0;
    push_valid        = 1'b0;
    push_data         = '0;
    credit_withhold   = '0;
    pop_ready         = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;

    initial_credit_pulses();
    fill_then_drain();
    bypass_same_cycle();
    random_traffic();
    stall_and_withhold();

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule : tb_fifo_credit_top

//--- source/cfifo_params.svh
// Credit FIFO build constants
`ifndef CFIFO_PARAMS_SVH
`define CFIFO_PARAMS_SVH

// ------------------------------------------------------------
// Storage geometry
// ------------------------------------------------------------

// Number of flop entries
`define CFIFO_DEPTH 8

// Data word width in bits
`define CFIFO_WIDTH 16

// ------------------------------------------------------------
// Credit setup
// ------------------------------------------------------------

// Credits held by the receiver out of reset
// One per storage entry
`define CFIFO_CREDIT_INIT `CFIFO_DEPTH

// ------------------------------------------------------------
// Derived widths
// ------------------------------------------------------------

// RAM index
`define CFIFO_ADDR_W $clog2(`CFIFO_DEPTH)

// Counts from 0 up to and including depth
`define CFIFO_COUNT_W $clog2(`CFIFO_DEPTH + 1)

// Credit counter sized for the initial credit
`define CFIFO_CREDIT_W $clog2(`CFIFO_CREDIT_INIT + 1)

`endif

//--- source/cfifo_pkg.sv
// Credit FIFO shared types
`include "cfifo_params.svh"

package cfifo_pkg;

  // ------------------------------------------------------------
  // Datapath
  // ------------------------------------------------------------

  // One FIFO word
  typedef logic [`CFIFO_WIDTH-1:0] data_t;

  // Index into the flop RAM
  typedef logic [`CFIFO_ADDR_W-1:0] addr_t;

  // ------------------------------------------------------------
  // Control
  // ------------------------------------------------------------

  // Free slots or stored items, 0 to depth
  typedef logic [`CFIFO_COUNT_W-1:0] count_t;

  // Credit count, also used for the withhold amount
  typedef logic [`CFIFO_CREDIT_W-1:0] credit_t;

endpackage : cfifo_pkg

//--- source/credit_receiver.sv
// Credit receiver for the push side
`include "cfifo_params.svh"

module credit_receiver
  import cfifo_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,

  // Sender side
  input  logic    push_credit_stall,
  output logic    push_credit,
  input  logic    push_valid,

  // Credit returned by the FIFO
  input  logic    pop_credit,

  // Credit pool control and status
  input  credit_t credit_withhold,
  output credit_t credit_count,
  output credit_t credit_available
);

  // ------------------------------------------------------------
  // Available pool
  // ------------------------------------------------------------

  credit_t credit_count_next;

  // Withheld credits never go to the sender
  // Clamp at zero when the withhold exceeds the count
  always_comb begin
    if (credit_count > credit_withhold) begin
      credit_available = credit_count - credit_withhold;
    end else begin
      credit_available = '0;
    end
  end

  // At most one credit per cycle
  // Stall blocks issue but keeps the pool intact
  assign push_credit = (credit_available != '0) && !push_credit_stall;

  // ------------------------------------------------------------
  // Credit counter
  // ------------------------------------------------------------

  // Return adds one, issue takes one, both cancel
  always_comb begin
    credit_count_next = credit_count;
    if (pop_credit && !push_credit) begin
      credit_count_next = credit_count + credit_t'(1);
    end else if (!pop_credit && push_credit) begin
      credit_count_next = credit_count - credit_t'(1);
    end
  end

  // Full pool of credits right out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_count <= credit_t'(`CFIFO_CREDIT_INIT);
    end else begin
      credit_count <= credit_count_next;
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  // Returned credits must match issued ones
  credit_count_in_range_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    credit_count <= credit_t'(`CFIFO_DEPTH)
  );

  // All credits home means the sender holds none
  no_push_without_credit_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    (credit_count == credit_t'(`CFIFO_CREDIT_INIT)) && !pop_credit |-> !push_valid
  );

endmodule : credit_receiver

//--- source/fifo_credit_top.sv
// Credit flow FIFO top level
`include "cfifo_params.svh"

module fifo_credit_top
  import cfifo_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,

  // Push side, credit based
  input  logic    push_credit_stall,
  output logic    push_credit,
  input  logic    push_valid,
  input  data_t   push_data,

  // Credit pool
  input  credit_t credit_withhold,
  output credit_t credit_available,

  // Push side status
  output logic    full,
  output count_t  slots,

  // Pop side, valid/ready
  input  logic    pop_ready,
  output logic    pop_valid,
  output data_t   pop_data,

  // Pop side status
  output count_t  items
);

  // ------------------------------------------------------------
  // Internal wires
  // ------------------------------------------------------------

  // Bypass path
  logic  bypass_ready;
  logic  bypass_valid;
  data_t bypass_data;

  // RAM write port
  logic  ram_wr_valid;
  addr_t ram_wr_addr;
  data_t ram_wr_data;

  // RAM read port
  addr_t ram_rd_addr;
  data_t ram_rd_data;

  // Controller handshakes
  logic  ram_push;
  logic  ram_pop;

  // ------------------------------------------------------------
  // Push side
  // ------------------------------------------------------------

  // Raw credit count not exported
  fifo_push_ctrl_credit fifo_push_ctrl_credit_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .push_credit_stall(push_credit_stall),
    .push_credit      (push_credit),
    .push_valid       (push_valid),
    .push_data        (push_data),
    .credit_withhold  (credit_withhold),
    .credit_count     (),
    .credit_available (credit_available),
    .full             (full),
    .slots            (slots),
    .bypass_ready     (bypass_ready),
    .bypass_valid     (bypass_valid),
    .bypass_data      (bypass_data),
    .ram_wr_valid     (ram_wr_valid),
    .ram_wr_addr      (ram_wr_addr),
    .ram_wr_data      (ram_wr_data),
    .ram_push         (ram_push),
    .ram_pop          (ram_pop)
  );

  // ------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------

  fifo_ram_flops fifo_ram_flops_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_valid(ram_wr_valid),
    .wr_addr (ram_wr_addr),
    .wr_data (ram_wr_data),
    .rd_addr (ram_rd_addr),
    .rd_data (ram_rd_data)
  );

  // ------------------------------------------------------------
  // Pop side
  // ------------------------------------------------------------

  fifo_pop_ctrl fifo_pop_ctrl_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .ram_push    (ram_push),
    .bypass_valid(bypass_valid),
    .bypass_data (bypass_data),
    .bypass_ready(bypass_ready),
    .ram_rd_addr (ram_rd_addr),
    .ram_rd_data (ram_rd_data),
    .ram_pop     (ram_pop),
    .pop_ready   (pop_ready),
    .pop_valid   (pop_valid),
    .pop_data    (pop_data),
    .items       (items)
  );

endmodule : fifo_credit_top

//--- source/fifo_pop_ctrl.sv
// FIFO pop controller with bypass
`include "cfifo_params.svh"

module fifo_pop_ctrl
  import cfifo_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,

  // Events from the push controller
  input  logic   ram_push,

  // Bypass from the push controller
  input  logic   bypass_valid,
  input  data_t  bypass_data,
  output logic   bypass_ready,

  // RAM read port
  output addr_t  ram_rd_addr,
  input  data_t  ram_rd_data,

  // Stored word left the RAM
  output logic   ram_pop,

  // Pop side
  input  logic   pop_ready,
  output logic   pop_valid,
  output data_t  pop_data,

  // Pop side status
  output count_t items
);

  // ------------------------------------------------------------
  // Output select
  // ------------------------------------------------------------

  logic   ram_not_empty;
  count_t items_next;

  assign ram_not_empty = (items != '0);

  // Stored words go first to keep order
  // Empty RAM passes the push word through
  assign pop_valid = ram_not_empty || bypass_valid;
  assign pop_data  = ram_not_empty ? ram_rd_data : bypass_data;

  // Bypass only into an empty FIFO with a ready consumer
  assign bypass_ready = !ram_not_empty && pop_ready;

  // Head of the RAM accepted
  assign ram_pop = ram_not_empty && pop_ready;

  // ------------------------------------------------------------
  // Item count
  // ------------------------------------------------------------

  always_comb begin
    items_next = items;
    if (ram_push && !ram_pop) begin
      items_next = items + count_t'(1);
    end else if (!ram_push && ram_pop) begin
      items_next = items - count_t'(1);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      items <= '0;
    end else begin
      items <= items_next;
    end
  end

  // ------------------------------------------------------------
  // Read pointer
  // ------------------------------------------------------------

  // Points at the oldest stored word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ram_rd_addr <= '0;
    end else if (ram_pop) begin
      if (ram_rd_addr == addr_t'(`CFIFO_DEPTH - 1)) begin
        ram_rd_addr <= '0;
      end else begin
        ram_rd_addr <= ram_rd_addr + addr_t'(1);
      end
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  // Credits bound the stored words
  items_in_range_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    items <= count_t'(`CFIFO_DEPTH)
  );

  // Bypassed word must not also be stored by the push side
  bypass_leaves_fifo_empty_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    bypass_valid && bypass_ready |=> (items == '0)
  );

  // Offered word held until taken
  pop_data_stable_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    pop_valid && !pop_ready |=> pop_valid && $stable(pop_data)
  );

endmodule : fifo_pop_ctrl

//--- source/fifo_push_ctrl_credit.sv
// FIFO push controller with credit flow
`include "cfifo_params.svh"

module fifo_push_ctrl_credit
  import cfifo_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,

  // Push side
  input  logic    push_credit_stall,
  output logic    push_credit,
  input  logic    push_valid,
  input  data_t   push_data,

  // Credit pool
  input  credit_t credit_withhold,
  output credit_t credit_count,
  output credit_t credit_available,

  // Push side status
  output logic    full,
  output count_t  slots,

  // Bypass offer to the pop controller
  input  logic    bypass_ready,
  output logic    bypass_valid,
  output data_t   bypass_data,

  // RAM write port
  output logic    ram_wr_valid,
  output addr_t   ram_wr_addr,
  output data_t   ram_wr_data,

  // Push and pop events between controllers
  output logic    ram_push,
  input  logic    ram_pop
);

  // ------------------------------------------------------------
  // Credit return
  // ------------------------------------------------------------

  logic   bypass_taken;
  logic   pop_credit;
  count_t slots_next;

  // Word goes straight out, so its slot never fills
  assign bypass_taken = push_valid && bypass_ready;

  // Bypass needs an empty FIFO and ram_pop a non-empty one
  // so at most one credit returns per cycle
  assign pop_credit = ram_pop || bypass_taken;

  credit_receiver credit_receiver_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .push_credit_stall(push_credit_stall),
    .push_credit      (push_credit),
    .push_valid       (push_valid),
    .pop_credit       (pop_credit),
    .credit_withhold  (credit_withhold),
    .credit_count     (credit_count),
    .credit_available (credit_available)
  );

  // ------------------------------------------------------------
  // Datapath
  // ------------------------------------------------------------

  // Every word is offered to the bypass
  assign bypass_valid = push_valid;
  assign bypass_data  = push_data;

  // Otherwise it lands in the RAM
  assign ram_push     = push_valid && !bypass_ready;
  assign ram_wr_valid = ram_push;
  assign ram_wr_data  = push_data;

  // Write pointer wraps at the last entry
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ram_wr_addr <= '0;
    end else if (ram_push) begin
      if (ram_wr_addr == addr_t'(`CFIFO_DEPTH - 1)) begin
        ram_wr_addr <= '0;
      end else begin
        ram_wr_addr <= ram_wr_addr + addr_t'(1);
      end
    end
  end

  // ------------------------------------------------------------
  // Slot count and full flag
  // ------------------------------------------------------------

  always_comb begin
    slots_next = slots;
    if (ram_push && !ram_pop) begin
      slots_next = slots - count_t'(1);
    end else if (!ram_push && ram_pop) begin
      slots_next = slots + count_t'(1);
    end
  end

  // All slots free after reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slots <= count_t'(`CFIFO_DEPTH);
      full  <= 1'b0;
    end else if (ram_push || ram_pop) begin
      slots <= slots_next;
      full  <= (slots_next == '0);
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  // Sender must be out of credits before storage runs out
  no_credit_when_full_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    full |-> !push_credit
  );

  // Pop controller sees an empty RAM here too
  no_ram_pop_when_all_slots_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    (slots == count_t'(`CFIFO_DEPTH)) |-> !ram_pop
  );

  // Taken bypass only into an empty FIFO
  bypass_only_when_empty_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    bypass_taken |-> (slots == count_t'(`CFIFO_DEPTH))
  );

endmodule : fifo_push_ctrl_credit

//--- source/fifo_ram_flops.sv
// Flop based FIFO storage
`include "cfifo_params.svh"

module fifo_ram_flops
  import cfifo_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,

  // Registered write port
  input  logic  wr_valid,
  input  addr_t wr_addr,
  input  data_t wr_data,

  // Combinational read port
  input  addr_t rd_addr,
  output data_t rd_data
);

  // Storage array
  data_t mem [`CFIFO_DEPTH];

  // One entry written per cycle
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Same cycle read mux
  assign rd_data = mem[rd_addr];

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  // Write lands on a known, existing entry
  wr_addr_in_range_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_valid |-> !$isunknown(wr_addr) && (int'(wr_addr) < `CFIFO_DEPTH)
  );

endmodule : fifo_ram_flops

//--- verilog.f
+incdir+source
source/cfifo_pkg.sv
source/credit_receiver.sv
source/fifo_ram_flops.sv
source/fifo_push_ctrl_credit.sv
source/fifo_pop_ctrl.sv
source/fifo_credit_top.sv
sim/tb_fifo_credit_top.sv
